// File: logic/chartData.svh
`ifndef CHART_DATA_SVH
`define CHART_DATA_SVH

// needs laneT in scope where it is included
localparam int CHART_STEPS = 60;

// one entry per step, in the order notes enter row 2
localparam laneT CHART [CHART_STEPS] = '{
	// first phrase
	laneNone,   laneNone,   laneLeft,   laneCenter, laneCenter, laneRight,
	laneRight,  laneRight,  laneRight,  laneCenter, laneLeft,   laneLeft,
	laneRight,
	// repeat of the first phrase
	laneNone,   laneNone,   laneLeft,   laneCenter, laneCenter, laneRight,
	laneRight,  laneRight,  laneRight,  laneCenter, laneLeft,   laneLeft,
	laneRight,
	// short bridge
	laneNone,   laneNone,   laneRight,  laneCenter, laneLeft,   laneRight,
	laneRight,  laneCenter, laneRight,  laneLeft,
	// right-heavy run
	laneNone,   laneNone,   laneCenter, laneRight,  laneRight,  laneCenter,
	laneRight,  laneRight,  laneCenter, laneRight,  laneRight,  laneLeft,
	// closing phrase, mostly left
	laneNone,   laneNone,   laneLeft,   laneLeft,   laneLeft,   laneLeft,
	laneRight,  laneCenter, laneCenter, laneLeft,   laneLeft,   laneRight
};

`endif

// File: logic/gamePkg.sv
package gamePkg;

	// lane code carried by every chart step and every note row
	typedef enum logic [1:0] {
		laneNone   = 2'd0,
		laneLeft   = 2'd1,
		laneCenter = 2'd2,
		laneRight  = 2'd3
	} laneT;

	// one matrix row, LEDs lit on a zero
	typedef logic [7:0] rowPatternT;

	localparam rowPatternT DARK_ROW     = 8'b11111111;
	localparam rowPatternT LEFT_BLOCK   = 8'b00011111;
	localparam rowPatternT CENTER_BLOCK = 8'b11100111;
	localparam rowPatternT RIGHT_BLOCK  = 8'b11111000;

	// rows 2 to 7 scroll, rows 0 and 1 are fixed
	localparam int NOTE_ROWS = 6;

	// empty steps that push the last notes off the bottom
	localparam int FLUSH_STEPS = 6;
	// fully dark steps between songs
	localparam int BLANK_STEPS = 2;

	localparam int SCORE_W = 8;

	`include "chartData.svh"

	// block shape for a lane, nothing lit when empty
	function automatic rowPatternT lanePattern(laneT lane);
		case (lane)
			laneLeft: begin
				return LEFT_BLOCK;
			end
			laneCenter: begin
				return CENTER_BLOCK;
			end
			laneRight: begin
				return RIGHT_BLOCK;
			end
			default: begin
				return DARK_ROW;
			end
		endcase
	endfunction

endpackage

// File: logic/beatTimer.sv
`timescale 1ns/1ps

module beatTimer #(
	parameter int STEP_CYCLES = 25000000,
	parameter int SCAN_CYCLES = 8192
) (
	input  logic clk,
	input  logic reset,
	output logic stepTick,
	output logic scanAdvance
);

	localparam int STEP_W = $clog2(STEP_CYCLES);
	localparam int SCAN_W = $clog2(SCAN_CYCLES);

	logic [STEP_W-1:0] stepCnt;
	logic [SCAN_W-1:0] scanCnt;

	// chart step rate
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			stepCnt  <= STEP_W'(STEP_CYCLES - 1);
			stepTick <= 1'b0;
		end else if (stepCnt == '0) begin
			stepCnt  <= STEP_W'(STEP_CYCLES - 1);
			stepTick <= 1'b1;
		end else begin
			stepCnt  <= stepCnt - 1'b1;
			stepTick <= 1'b0;
		end
	end

	// row multiplex rate
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			scanCnt     <= SCAN_W'(SCAN_CYCLES - 1);
			scanAdvance <= 1'b0;
		end else if (scanCnt == '0) begin
			scanCnt     <= SCAN_W'(SCAN_CYCLES - 1);
			scanAdvance <= 1'b1;
		end else begin
			scanCnt     <= scanCnt - 1'b1;
			scanAdvance <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!reset) stepTick |=> !stepTick);

endmodule

// File: logic/noteScroller.sv
`timescale 1ns/1ps

module noteScroller (
	input  logic          clk,
	input  logic          reset,
	input  logic          stepTick,
	output gamePkg::laneT noteRows [gamePkg::NOTE_ROWS],
	output gamePkg::laneT arrivingLane,
	output logic          songBlank,
	output logic          songRestart
);

	import gamePkg::*;

	typedef enum logic [1:0] {
		phasePlay,
		phaseFlush,
		phaseBlank
	} phaseT;

	localparam int MAX_LEN = (CHART_STEPS > FLUSH_STEPS) ?
		((CHART_STEPS > BLANK_STEPS) ? CHART_STEPS : BLANK_STEPS) :
		((FLUSH_STEPS > BLANK_STEPS) ? FLUSH_STEPS : BLANK_STEPS);
	localparam int STEP_W = $clog2(MAX_LEN);

	phaseT phase;
	phaseT nextPhase;
	logic [STEP_W-1:0] stepCnt;
	int phaseLen;
	logic phaseDone;
	laneT nextEntry;
	logic rowsEmpty;

	// length of the current phase and what follows it
	always_comb begin
		case (phase)
			phasePlay: begin
				phaseLen  = CHART_STEPS;
				nextPhase = phaseFlush;
				nextEntry = CHART[stepCnt];
			end
			phaseFlush: begin
				phaseLen  = FLUSH_STEPS;
				nextPhase = phaseBlank;
				nextEntry = laneNone;
			end
			default: begin
				phaseLen  = BLANK_STEPS;
				nextPhase = phasePlay;
				nextEntry = laneNone;
			end
		endcase
	end

	assign phaseDone = (int'(stepCnt) == phaseLen - 1);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			phase   <= phasePlay;
			stepCnt <= '0;
			for (int i = 0; i < NOTE_ROWS; i++) begin
				noteRows[i] <= laneNone;
			end
		end else if (stepTick) begin
			// new entry at row 2, everything else moves down one
			noteRows[0] <= nextEntry;
			for (int i = 1; i < NOTE_ROWS; i++) begin
				noteRows[i] <= noteRows[i - 1];
			end
			if (phaseDone) begin
				stepCnt <= '0;
				phase   <= nextPhase;
			end else begin
				stepCnt <= stepCnt + 1'b1;
			end
		end
	end

	// row 6, moves into row 7 on the next tick
	assign arrivingLane = noteRows[NOTE_ROWS - 2];
	assign songBlank    = (phase == phaseBlank);
	assign songRestart  = stepTick && phaseDone && (phase == phaseBlank);

	always_comb begin
		rowsEmpty = 1'b1;
		for (int i = 0; i < NOTE_ROWS; i++) begin
			if (noteRows[i] != laneNone) begin
				rowsEmpty = 1'b0;
			end
		end
	end

	// flush must have cleared every row before the dark steps
	assert property (@(posedge clk) disable iff (!reset) songBlank |-> rowsEmpty);

	assert property (@(posedge clk) disable iff (!reset) int'(stepCnt) < phaseLen);

endmodule

// File: logic/hitJudge.sv
`timescale 1ns/1ps

module hitJudge (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        stepTick,
	input  logic                        songRestart,
	input  gamePkg::laneT               arrivingLane,
	input  logic                        left,
	input  logic                        center,
	input  logic                        right,
	output logic [gamePkg::SCORE_W-1:0] score
);

	import gamePkg::*;

	logic pressed;

	// buttons are active low, only the lane of the arriving note counts
	always_comb begin
		case (arrivingLane)
			laneLeft: begin
				pressed = !left;
			end
			laneCenter: begin
				pressed = !center;
			end
			laneRight: begin
				pressed = !right;
			end
			default: begin
				pressed = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			score <= '0;
		end else if (songRestart) begin
			score <= '0;
		end else if (stepTick && pressed) begin
			score <= score + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!reset) !stepTick |=> $stable(score));

endmodule

// File: logic/matrixScanner.sv
`timescale 1ns/1ps

module matrixScanner (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        scanAdvance,
	input  gamePkg::laneT               noteRows [gamePkg::NOTE_ROWS],
	input  logic [gamePkg::SCORE_W-1:0] score,
	input  logic                        songBlank,
	output gamePkg::rowPatternT         segout,
	output logic [2:0]                  scanout
);

	import gamePkg::*;

	logic [2:0] noteIdx;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			scanout <= '0;
		end else if (scanAdvance) begin
			scanout <= scanout + 1'b1;
		end
	end

	// rows 2..7 map onto note slots 0..5
	assign noteIdx = scanout - 3'd2;

	always_comb begin
		if (songBlank) begin
			segout = DARK_ROW;
		end else if (scanout == 3'd0) begin
			// score shown as raw bits
			segout = rowPatternT'(score);
		end else if (scanout == 3'd1) begin
			segout = DARK_ROW;
		end else begin
			segout = lanePattern(noteRows[noteIdx]);
		end
	end

endmodule

// File: logic/musicGameTop.sv
`timescale 1ns/1ps

module musicGameTop #(
	parameter int STEP_CYCLES = 25000000,
	parameter int SCAN_CYCLES = 8192
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                left,
	input  logic                center,
	input  logic                right,
	output gamePkg::rowPatternT segout,
	output logic [2:0]          scanout
);

	import gamePkg::*;

	logic stepTick;
	logic scanAdvance;
	laneT noteRows [NOTE_ROWS];
	laneT arrivingLane;
	logic songBlank;
	logic songRestart;
	logic [SCORE_W-1:0] score;

	beatTimer #(
		.STEP_CYCLES(STEP_CYCLES),
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_beatTimer (
		.clk        (clk),
		.reset      (reset),
		.stepTick   (stepTick),
		.scanAdvance(scanAdvance)
	);

	noteScroller u_noteScroller (
		.clk         (clk),
		.reset       (reset),
		.stepTick    (stepTick),
		.noteRows    (noteRows),
		.arrivingLane(arrivingLane),
		.songBlank   (songBlank),
		.songRestart (songRestart)
	);

	hitJudge u_hitJudge (
		.clk         (clk),
		.reset       (reset),
		.stepTick    (stepTick),
		.songRestart (songRestart),
		.arrivingLane(arrivingLane),
		.left        (left),
		.center      (center),
		.right       (right),
		.score       (score)
	);

	matrixScanner u_matrixScanner (
		.clk        (clk),
		.reset      (reset),
		.scanAdvance(scanAdvance),
		.noteRows   (noteRows),
		.score      (score),
		.songBlank  (songBlank),
		.segout     (segout),
		.scanout    (scanout)
	);

endmodule

// File: dv/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
	end

endmodule

// File: dv/gameChecker.sv
`timescale 1ns/1ps

module gameChecker #(
	parameter int STEP_CYCLES = 40,
	parameter int SCAN_CYCLES = 2
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                left,
	input  logic                center,
	input  logic                right,
	input  gamePkg::rowPatternT segout,
	input  logic [2:0]          scanout,
	output gamePkg::laneT       arriveLane,
	output int                  stepNum,
	output int                  songNum,
	output int                  checkCount,
	output int                  errorCount
);

	import gamePkg::*;

	`include "chartData.svh"

	localparam int PHASE_PLAY  = 0;
	localparam int PHASE_BLANK = 2;

	int cyc;
	int phase;
	int stepIdx;
	int testErrors;
	laneT rows [NOTE_ROWS];
	logic [SCORE_W-1:0] score;
	logic [2:0] scanRow;
	rowPatternT expected;

	function automatic int phaseLen(int p);
		case (p)
			0: return CHART_STEPS;
			1: return FLUSH_STEPS;
			default: return BLANK_STEPS;
		endcase
	endfunction

	// active-low buttons, only the arriving lane's button counts
	function automatic logic hitFor(laneT lane, logic l, logic c, logic r);
		case (lane)
			laneLeft: return !l;
			laneCenter: return !c;
			laneRight: return !r;
			default: return 1'b0;
		endcase
	endfunction

	function automatic rowPatternT blockFor(laneT lane);
		case (lane)
			laneLeft: return LEFT_BLOCK;
			laneCenter: return CENTER_BLOCK;
			laneRight: return RIGHT_BLOCK;
			default: return DARK_ROW;
		endcase
	endfunction

	function automatic rowPatternT expectedRow(logic [2:0] r);
		if (phase == PHASE_BLANK) begin
			return DARK_ROW;
		end
		if (r == 3'd0) begin
			return rowPatternT'(score);
		end
		if (r == 3'd1) begin
			return DARK_ROW;
		end
		return blockFor(rows[int'(r) - 2]);
	endfunction

	function automatic string testName(int n);
		case (n)
			0: return "no presses";
			1: return "matching presses";
			2: return "random presses";
			default: return "restart pass";
		endcase
	endfunction

	task automatic initModel();
		cyc = 0;
		phase = PHASE_PLAY;
		stepIdx = 0;
		stepNum = 0;
		score = '0;
		scanRow = '0;
		for (int i = 0; i < NOTE_ROWS; i++) begin
			rows[i] = laneNone;
		end
	endtask

	task automatic reportMismatch(string what);
		errorCount++;
		testErrors++;
		$display("FAIL %0t: %s", $time, what);
	endtask

	// one chart step: judge the arriving note, then shift
	task automatic stepModel();
		logic restart;
		restart = (phase == PHASE_BLANK) && (stepIdx == BLANK_STEPS - 1);
		if (restart) begin
			score = '0;
		end else if (hitFor(rows[NOTE_ROWS - 2], left, center, right)) begin
			score = score + SCORE_W'(1);
		end
		for (int i = NOTE_ROWS - 1; i > 0; i--) begin
			rows[i] = rows[i - 1];
		end
		if (phase == PHASE_PLAY) begin
			rows[0] = CHART[stepIdx];
		end else begin
			rows[0] = laneNone;
		end
		stepIdx++;
		if (stepIdx == phaseLen(phase)) begin
			stepIdx = 0;
			phase = (phase + 1) % 3;
		end
		stepNum++;
		if (restart) begin
			$display("test %0d (%s) finished: %0d mismatches", songNum + 1,
				testName(songNum), testErrors);
			testErrors = 0;
			songNum++;
		end
	endtask

	initial begin
		songNum = 0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		initModel();
	end

	assign arriveLane = rows[NOTE_ROWS - 2];

	// tick and scan edges follow from the cycle count alone
	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			initModel();
		end else begin
			if (cyc != 0 && cyc % STEP_CYCLES == 0) begin
				stepModel();
			end
			if (cyc != 0 && cyc % SCAN_CYCLES == 0) begin
				scanRow = scanRow + 3'd1;
			end
			cyc++;
		end
	end

	always @(negedge clk) begin
		if (reset && cyc > 0) begin
			expected = expectedRow(scanRow);
			checkCount++;
			if (scanout !== scanRow) begin
				reportMismatch($sformatf("scanout %0d, expected %0d", scanout, scanRow));
			end else if (segout !== expected) begin
				reportMismatch($sformatf("row %0d shows %b, expected %b",
					scanRow, segout, expected));
			end
		end
	end

endmodule

// File: dv/musicGameTb.sv
`timescale 1ns/1ps

module musicGameTb;

	import gamePkg::*;

	localparam int STEP_CYCLES = 40;
	localparam int SCAN_CYCLES = 2;
	localparam int CLK_PERIOD  = 8;
	localparam int SONGS       = 4;
	localparam int SONG_STEPS  = CHART_STEPS + FLUSH_STEPS + BLANK_STEPS;
	// four songs of steps plus a few spare steps and the reset
	localparam int TIMEOUT_NS  = ((SONGS * SONG_STEPS + 8) * STEP_CYCLES + 10) * CLK_PERIOD;

	logic clk;
	logic reset;
	logic left;
	logic center;
	logic right;
	rowPatternT segout;
	logic [2:0] scanout;
	laneT arriveLane;
	int stepNum;
	int songNum;
	int checkCount;
	int errorCount;
	logic [15:0] lfsr;
	int lastStep;

	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic holdButtons(logic l, logic c, logic r);
		left = l;
		center = c;
		right = r;
	endtask

	task automatic pressRandom();
		lfsr = lfsrNext(lfsr);
		left = lfsr[0];
		lfsr = lfsrNext(lfsr);
		center = lfsr[0];
		lfsr = lfsrNext(lfsr);
		right = lfsr[0];
	endtask

	// hold the button of the note that reaches row 7 on the next tick
	task automatic pressMatching();
		case (arriveLane)
			laneLeft: holdButtons(1'b0, 1'b1, 1'b1);
			laneCenter: holdButtons(1'b1, 1'b0, 1'b1);
			laneRight: holdButtons(1'b1, 1'b1, 1'b0);
			default: holdButtons(1'b1, 1'b1, 1'b1);
		endcase
	endtask

	tbClock #(
		.PERIOD      (CLK_PERIOD),
		.RESET_CYCLES(3)
	) u_tbClock (
		.clk  (clk),
		.reset(reset)
	);

	musicGameTop #(
		.STEP_CYCLES(STEP_CYCLES),
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_musicGameTop (
		.clk    (clk),
		.reset  (reset),
		.left   (left),
		.center (center),
		.right  (right),
		.segout (segout),
		.scanout(scanout)
	);

	gameChecker #(
		.STEP_CYCLES(STEP_CYCLES),
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_gameChecker (
		.clk       (clk),
		.reset     (reset),
		.left      (left),
		.center    (center),
		.right     (right),
		.segout    (segout),
		.scanout   (scanout),
		.arriveLane(arriveLane),
		.stepNum   (stepNum),
		.songNum   (songNum),
		.checkCount(checkCount),
		.errorCount(errorCount)
	);

	initial begin
		holdButtons(1'b1, 1'b1, 1'b1);
		lfsr = 16'd46;
		lastStep = -1;
	end

	// new buttons once per step, held until the next one
	always @(negedge clk) begin
		if (reset && stepNum != lastStep) begin
			lastStep = stepNum;
			case (songNum)
				1, 3: pressMatching();
				2: pressRandom();
				default: holdButtons(1'b1, 1'b1, 1'b1);
			endcase
		end
	end

	initial begin
		wait (songNum == SONGS);
		repeat (4) @(negedge clk);
		$display("tests %0d, checks %0d, errors %0d", songNum, checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("run timed out at %0t with %0d of %0d tests finished", $time, songNum, SONGS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: project.f
+incdir+logic
logic/gamePkg.sv
logic/beatTimer.sv
logic/noteScroller.sv
logic/hitJudge.sv
logic/matrixScanner.sv
logic/musicGameTop.sv
dv/tbClock.sv
dv/gameChecker.sv
dv/musicGameTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = musicGameTb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
